//--- Makefile
SIM       = verilator
TOP       = controlUnit_tb
FILELIST  = compile.f
BUILDDIR  = obj_dir
LOG       = sim.log
PASSMSG   = Testbench passed
SIMFLAGS  = --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS = --lint-only --timing -Wall --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: build
	./$(BUILDDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- compile.f
+incdir+design
design/cu_pkg.sv
design/controlSequencer.sv
design/controlWordGen.sv
design/controlUnit.sv
dv/controlUnit_assert.sv
dv/controlUnit_checker.sv
dv/controlUnit_tb.sv

//--- design/controlSequencer.sv
`default_nettype none

`include "cu_params.svh"

module controlSequencer (
    input wire clk,
    input wire reset,
    input wire cu_pkg::opcodeT opcode,
    input wire cu_pkg::functT funct,
    output cu_pkg::phaseT phase,
    output logic [`CU_STEP_W-1:0] step
);

    localparam logic [`CU_STEP_W-1:0] lastFetchStep = `CU_STEP_W'(`CU_FETCH_STEPS - 1);
    localparam logic [`CU_STEP_W-1:0] lastAddStep = `CU_STEP_W'(`CU_ADD_STEPS - 1);

    logic isAdd;

    // Only consulted on the decode step
    assign isAdd = (opcode == cu_pkg::opRType) && (funct == cu_pkg::fnAdd);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= cu_pkg::phaseReset;
            step <= '0;
        end else begin
            case (phase)
                cu_pkg::phaseReset: begin
                    // Reset released, start the first fetch
                    phase <= cu_pkg::phaseFetch;
                    step <= '0;
                end

                cu_pkg::phaseFetch: begin
                    if (step == lastFetchStep) begin
                        // Decode step
                        step <= '0;
                        if (isAdd) begin
                            phase <= cu_pkg::phaseAdd;
                        end else begin
                            // Unsupported instructions go straight back to fetch
                            phase <= cu_pkg::phaseFetch;
                        end
                    end else begin
                        step <= step + 1'b1;
                    end
                end

                cu_pkg::phaseAdd: begin
                    if (step == lastAddStep) begin
                        phase <= cu_pkg::phaseFetch;
                        step <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end

                default: begin
                    // Unused encoding, recover into fetch
                    phase <= cu_pkg::phaseFetch;
                    step <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/controlUnit.sv
`default_nettype none

`include "cu_params.svh"

module controlUnit (
    input wire clk,
    input wire reset,
    input wire cu_pkg::opcodeT opcode,
    input wire cu_pkg::functT funct,
    output logic pcWrite,
    output logic memRead,
    output logic irWrite,
    output logic regWrite,
    output logic controlA,
    output logic controlB,
    output logic aluOutWrite,
    output logic rstOut,
    output cu_pkg::aluOpT aluOp,
    output logic [`CU_ALUSRCA_W-1:0] aluSrcA,
    output logic [`CU_ALUSRCB_W-1:0] aluSrcB,
    output logic [`CU_REGDST_W-1:0] regDst,
    output logic [`CU_MEMTOREG_W-1:0] memToReg,
    output logic [`CU_SELBYTE_W-1:0] selectByteSrc
);

    // Phase and step executed on the next edge
    cu_pkg::phaseT phase;
    logic [`CU_STEP_W-1:0] step;

    controlSequencer sequencer (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .funct(funct),
        .phase(phase),
        .step(step)
    );

    controlWordGen wordGen (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .step(step),
        .pcWrite(pcWrite),
        .memRead(memRead),
        .irWrite(irWrite),
        .regWrite(regWrite),
        .controlA(controlA),
        .controlB(controlB),
        .aluOutWrite(aluOutWrite),
        .rstOut(rstOut),
        .aluOp(aluOp),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .regDst(regDst),
        .memToReg(memToReg),
        .selectByteSrc(selectByteSrc)
    );

endmodule

`default_nettype wire

//--- design/controlWordGen.sv
`default_nettype none

`include "cu_params.svh"

module controlWordGen (
    input wire clk,
    input wire reset,
    input wire cu_pkg::phaseT phase,
    input wire [`CU_STEP_W-1:0] step,
    output logic pcWrite,
    output logic memRead,
    output logic irWrite,
    output logic regWrite,
    output logic controlA,
    output logic controlB,
    output logic aluOutWrite,
    output logic rstOut,
    output cu_pkg::aluOpT aluOp,
    output logic [`CU_ALUSRCA_W-1:0] aluSrcA,
    output logic [`CU_ALUSRCB_W-1:0] aluSrcB,
    output logic [`CU_REGDST_W-1:0] regDst,
    output logic [`CU_MEMTOREG_W-1:0] memToReg,
    output logic [`CU_SELBYTE_W-1:0] selectByteSrc
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pcWrite <= 1'b0;
            memRead <= 1'b0;
            irWrite <= 1'b0;
            regWrite <= 1'b0;
            controlA <= 1'b0;
            controlB <= 1'b0;
            aluOutWrite <= 1'b0;
            rstOut <= 1'b1;
            aluOp <= cu_pkg::aluPass;
            aluSrcA <= '0;
            aluSrcB <= '0;
            regDst <= '0;
            memToReg <= '0;
            selectByteSrc <= '0;
        end else begin
            // Everything idles unless the row below says otherwise
            pcWrite <= 1'b0;
            memRead <= 1'b0;
            irWrite <= 1'b0;
            regWrite <= 1'b0;
            controlA <= 1'b0;
            controlB <= 1'b0;
            aluOutWrite <= 1'b0;
            rstOut <= 1'b0;
            aluOp <= cu_pkg::aluPass;
            aluSrcA <= '0;
            aluSrcB <= '0;
            regDst <= '0;
            memToReg <= '0;
            selectByteSrc <= '0;

            case (phase)
                cu_pkg::phaseFetch: begin
                    if (step <= 3'd3) begin
                        // Read instruction into IR, PC <= PC + 4
                        pcWrite <= 1'b1;
                        memRead <= 1'b1;
                        irWrite <= 1'b1;
                        aluOp <= cu_pkg::aluAdd;
                        aluSrcA <= `CU_SRCA_PC;
                        aluSrcB <= `CU_SRCB_FOUR;
                    end else if (step == 3'd4) begin
                        // Load A and B, branch target computed speculatively
                        memRead <= 1'b1;
                        controlA <= 1'b1;
                        controlB <= 1'b1;
                        aluOp <= cu_pkg::aluAdd;
                        aluSrcA <= `CU_SRCA_PC;
                        aluSrcB <= `CU_SRCB_OFFSET;
                    end
                    // Step 5 is decode, idle row
                end

                cu_pkg::phaseAdd: begin
                    controlA <= 1'b1;
                    controlB <= 1'b1;
                    regDst <= `CU_REGDST_RD;
                    aluSrcA <= `CU_SRCA_REGA;
                    aluSrcB <= `CU_SRCB_REGB;
                    if (step == 3'd0) begin
                        // A + B latched into ALUOut
                        aluOutWrite <= 1'b1;
                    end else begin
                        // Write back ALUOut to rd
                        regWrite <= 1'b1;
                        memToReg <= `CU_MEMTOREG_ALUOUT;
                        selectByteSrc <= `CU_SELBYTE_WORD;
                    end
                end

                default: begin
                    // Reset phase leaves the idle word
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/cu_params.svh
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// Instruction field widths
`define CU_OPCODE_W 6
`define CU_FUNCT_W 6

// Step counter and phase lengths
`define CU_STEP_W 3
`define CU_FETCH_STEPS 6
`define CU_ADD_STEPS 3

// Datapath mux select widths
`define CU_ALUSRCA_W 2
`define CU_ALUSRCB_W 3
`define CU_REGDST_W 2
`define CU_MEMTOREG_W 3
`define CU_SELBYTE_W 2

// ALU operand A sources
`define CU_SRCA_PC 2'd1
`define CU_SRCA_REGA 2'd2

// ALU operand B sources
`define CU_SRCB_REGB 3'd0
`define CU_SRCB_FOUR 3'd1
// Sign-extended, shifted immediate
`define CU_SRCB_OFFSET 3'd4

// Register file write address takes rd
`define CU_REGDST_RD 2'd1

// Register file write data from ALUOut
`define CU_MEMTOREG_ALUOUT 3'd6

// Full word passes through the byte selector
`define CU_SELBYTE_WORD 2'd2

`endif

//--- design/cu_pkg.sv
`default_nettype none

`include "cu_params.svh"

package cu_pkg;

    // Major state of the control unit
    typedef enum logic [1:0] {
        phaseReset,
        phaseFetch,
        phaseAdd
    } phaseT;

    // ALU operation codes driven on aluOp
    typedef enum logic [2:0] {
        aluPass = 3'd0,
        aluAdd  = 3'd1
    } aluOpT;

    // Primary opcode field, bits 31:26
    // Only the R-type class is decoded
    typedef enum logic [`CU_OPCODE_W-1:0] {
        opRType = 6'h00
    } opcodeT;

    // Function field of R-type instructions, bits 5:0
    typedef enum logic [`CU_FUNCT_W-1:0] {
        fnAdd = 6'h20
    } functT;

endpackage

`default_nettype wire

//--- dv/controlUnit_assert.sv
`default_nettype none

`include "cu_params.svh"

module controlUnit_assert (
    input wire clk,
    input wire pcWrite,
    input wire memRead,
    input wire irWrite,
    input wire regWrite,
    input wire controlA,
    input wire controlB,
    input wire aluOutWrite,
    input wire rstOut,
    input wire [2:0] aluOp,
    input wire [`CU_ALUSRCA_W-1:0] aluSrcA,
    input wire [`CU_ALUSRCB_W-1:0] aluSrcB,
    input wire [`CU_REGDST_W-1:0] regDst,
    input wire [`CU_MEMTOREG_W-1:0] memToReg,
    input wire [`CU_SELBYTE_W-1:0] selectByteSrc
);
    timeunit 1ns;
    timeprecision 100ps;

    logic othersIdle;

    assign othersIdle = !(pcWrite || memRead || irWrite || regWrite || controlA || controlB
        || aluOutWrite) && aluOp == '0 && aluSrcA == '0 && aluSrcB == '0 && regDst == '0
        && memToReg == '0 && selectByteSrc == '0;

    // IR only loads from a memory read
    irNeedsRead: assert property (@(posedge clk) irWrite |-> memRead)
        else $error("irWrite high without memRead");

    writeBackFromAluOut: assert property (@(posedge clk)
        regWrite |-> memToReg == `CU_MEMTOREG_ALUOUT)
        else $error("regWrite high with memToReg %0d", memToReg);

    resetWordIdle: assert property (@(posedge clk) rstOut |-> othersIdle)
        else $error("rstOut high while another control output is active");

endmodule

bind controlUnit controlUnit_assert assertions (.*);

`default_nettype wire

//--- dv/controlUnit_checker.sv
`default_nettype none

`include "cu_params.svh"

module controlUnit_checker #(
    parameter int wordW = 8 + 3 + `CU_ALUSRCA_W + `CU_ALUSRCB_W + `CU_REGDST_W
        + `CU_MEMTOREG_W + `CU_SELBYTE_W
) (
    input wire clk,
    input wire reset,
    input wire [`CU_OPCODE_W-1:0] opcode,
    input wire [`CU_FUNCT_W-1:0] funct,
    // Eight strobes, then aluOp and the mux selects, MSB first
    input wire [wordW-1:0] controlWord
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numFields = 14;
    localparam logic [wordW-1:0] resetWord = {8'b0000_0001, {(wordW - 8){1'b0}}};

    string fieldName [numFields] = '{"pcWrite", "memRead", "irWrite", "regWrite", "controlA",
        "controlB", "aluOutWrite", "rstOut", "aluOp", "aluSrcA", "aluSrcB", "regDst",
        "memToReg", "selectByteSrc"};
    int fieldWidth [numFields] = '{1, 1, 1, 1, 1, 1, 1, 1, 3, `CU_ALUSRCA_W, `CU_ALUSRCB_W,
        `CU_REGDST_W, `CU_MEMTOREG_W, `CU_SELBYTE_W};

    cu_pkg::phaseT modelPhase = cu_pkg::phaseReset;
    int modelStep = 0;
    logic [wordW-1:0] expWord = '0;
    bit armed = 1'b0;
    bit isAdd;
    int checkCount = 0;
    int errorCount = 0;
    int testFailures = 0;
    int regWriteCycles = 0;
    int regWritesAtStart = 0;
    int errorsAtStart = 0;

    // Expected word for one phase and step
    function automatic logic [wordW-1:0] rowWord(cu_pkg::phaseT ph, int st);
        if (ph == cu_pkg::phaseFetch && st <= 3) begin
            return {8'b1110_0000, cu_pkg::aluAdd, `CU_SRCA_PC, `CU_SRCB_FOUR, 7'b0};
        end else if (ph == cu_pkg::phaseFetch && st == 4) begin
            return {8'b0100_1100, cu_pkg::aluAdd, `CU_SRCA_PC, `CU_SRCB_OFFSET, 7'b0};
        end else if (ph == cu_pkg::phaseAdd && st == 0) begin
            return {8'b0000_1110, cu_pkg::aluPass, `CU_SRCA_REGA, `CU_SRCB_REGB,
                `CU_REGDST_RD, 5'b0};
        end else if (ph == cu_pkg::phaseAdd) begin
            return {8'b0001_1100, cu_pkg::aluPass, `CU_SRCA_REGA, `CU_SRCB_REGB,
                `CU_REGDST_RD, `CU_MEMTOREG_ALUOUT, `CU_SELBYTE_WORD};
        end
        // Fetch step 5 and the cycle leaving reset
        return '0;
    endfunction

    task automatic compareWord(input logic [wordW-1:0] expected, input logic [wordW-1:0] got);
        int i;
        int pos;
        logic [wordW-1:0] mask;
        logic [wordW-1:0] e;
        logic [wordW-1:0] g;
        pos = wordW;
        checkCount++;
        for (i = 0; i < numFields; i++) begin
            pos -= fieldWidth[i];
            mask = ~({wordW{1'b1}} << fieldWidth[i]);
            e = (expected >> pos) & mask;
            g = (got >> pos) & mask;
            if (e !== g) begin
                errorCount++;
                $display("ERR %0t %s expected %0h got %0h", $time, fieldName[i], e, g);
            end
        end
    endtask

    // Model of the sequence, one step per edge
    always @(posedge clk) begin
        if (reset) begin
            expWord = resetWord;
            modelPhase = cu_pkg::phaseReset;
            modelStep = 0;
        end else begin
            expWord = rowWord(modelPhase, modelStep);
            if ((modelPhase == cu_pkg::phaseFetch && modelStep < `CU_FETCH_STEPS - 1)
                || (modelPhase == cu_pkg::phaseAdd && modelStep < `CU_ADD_STEPS - 1)) begin
                modelStep++;
            end else begin
                // Only R-type ADD leaves fetch for the add phase
                isAdd = modelPhase == cu_pkg::phaseFetch && opcode == 6'h00 && funct == 6'h20;
                modelPhase = isAdd ? cu_pkg::phaseAdd : cu_pkg::phaseFetch;
                modelStep = 0;
            end
        end
        armed = 1'b1;
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (armed) begin
            compareWord(expWord, controlWord);
            if (controlWord[wordW-4]) begin
                regWriteCycles++;
            end
        end
    end

    task automatic endTest(input int id, input bit expectAdd, input bit interrupted,
        input int cycles);
        int expCycles;
        int expRegWrites;
        int regWrites;
        string kindName;
        expCycles = expectAdd ? `CU_FETCH_STEPS + `CU_ADD_STEPS : `CU_FETCH_STEPS;
        expRegWrites = (expectAdd && !interrupted) ? 2 : 0;
        regWrites = regWriteCycles - regWritesAtStart;
        kindName = interrupted ? "add with reset" : (expectAdd ? "add" : "other");
        if (!interrupted && cycles != expCycles) begin
            testFailures++;
            $display("Test %0d took %0d cycles instead of %0d", id, cycles, expCycles);
        end
        if (regWrites != expRegWrites) begin
            testFailures++;
            $display("Test %0d held regWrite for %0d cycles instead of %0d",
                id, regWrites, expRegWrites);
        end
        $display("test %0d (%s): %0d cycles, %s", id, kindName, cycles,
            (errorCount + testFailures == errorsAtStart) ? "ok" : "FAILED");
        regWritesAtStart = regWriteCycles;
        errorsAtStart = errorCount + testFailures;
    endtask

    function automatic int totalErrors();
        return errorCount + testFailures;
    endfunction

endmodule

`default_nettype wire

//--- dv/controlUnit_tb.sv
`default_nettype none

`include "cu_params.svh"

module controlUnit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // Instruction kinds in the stimulus table
    localparam int kindOther = 0;
    localparam int kindAdd = 1;
    // ADD with reset raised during its add phase
    localparam int kindReset = 2;
    localparam int numTests = 8;
    localparam int waitLimit = 20;

    typedef struct packed {
        int opcode;
        int funct;
        // Fetch cycle from which the real fields are held
        int presentAt;
        int kind;
    } testT;

    logic clk;
    logic reset;
    cu_pkg::opcodeT opcode;
    cu_pkg::functT funct;
    logic pcWrite;
    logic memRead;
    logic irWrite;
    logic regWrite;
    logic controlA;
    logic controlB;
    logic aluOutWrite;
    logic rstOut;
    cu_pkg::aluOpT aluOp;
    logic [`CU_ALUSRCA_W-1:0] aluSrcA;
    logic [`CU_ALUSRCB_W-1:0] aluSrcB;
    logic [`CU_REGDST_W-1:0] regDst;
    logic [`CU_MEMTOREG_W-1:0] memToReg;
    logic [`CU_SELBYTE_W-1:0] selectByteSrc;
    testT tests [numTests];
    bit timedOut;
    int testsRun;

    controlUnit DUT (.*);

    controlUnit_checker watcher (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .funct(funct),
        .controlWord({pcWrite, memRead, irWrite, regWrite, controlA, controlB, aluOutWrite,
            rstOut, aluOp, aluSrcA, aluSrcB, regDst, memToReg, selectByteSrc})
    );

    always #5 clk = ~clk;

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // Random fields that only the decode edge may look at
    task automatic driveJunk();
        opcode = cu_pkg::opcodeT'(6'($urandom));
        funct = cu_pkg::functT'(6'($urandom));
    endtask

    // Fetch row 0 shows up as a rising irWrite
    task automatic waitFetchStart(output bit ok, output int cycles);
        bit prevIr;
        ok = 1'b0;
        prevIr = irWrite;
        for (cycles = 0; cycles < waitLimit && !ok; ) begin
            nextCycle();
            driveJunk();
            cycles++;
            ok = irWrite && !prevIr;
            prevIr = irWrite;
        end
        if (!ok) begin
            $display("Timeout: fetch did not restart within %0d cycles", waitLimit);
        end
    endtask

    task automatic runTest(input int id, input testT t, output bit ok);
        int c;
        int n;
        int elapsed;
        elapsed = 0;
        // Fields driven at c = 4 are the ones sampled by decode
        for (c = 0; c < `CU_FETCH_STEPS - 1; c++) begin
            if (c > 0) begin
                nextCycle();
                elapsed++;
            end
            if (c >= t.presentAt) begin
                opcode = cu_pkg::opcodeT'(t.opcode[5:0]);
                funct = cu_pkg::functT'(t.funct[5:0]);
            end else begin
                driveJunk();
            end
        end
        if (t.kind == kindReset) begin
            // Reset lands on add step 1 once decode and add step 0 have passed
            repeat (2) begin
                nextCycle();
                driveJunk();
                elapsed++;
            end
            reset = 1'b1;
            repeat (3) begin
                nextCycle();
                elapsed++;
            end
            reset = 1'b0;
        end
        waitFetchStart(ok, n);
        if (ok) begin
            watcher.endTest(id, t.kind != kindOther, t.kind == kindReset, elapsed + n);
        end
    endtask

    initial begin
        bit ok;
        int n;
        int i;
        void'($urandom(49946));
        clk = 1'b0;
        reset = 1'b1;
        opcode = cu_pkg::opRType;
        funct = cu_pkg::fnAdd;
        timedOut = 1'b0;
        testsRun = 0;
        tests[0] = '{32'h00, 32'h20, 4, kindAdd};
        tests[1] = '{32'h00, 32'h22, 0, kindOther};
        tests[2] = '{32'h00, 32'h20, 0, kindAdd};
        tests[3] = '{32'h23, 32'h20, 2, kindOther};
        tests[4] = '{32'h00, 32'h21, 3, kindOther};
        tests[5] = '{32'h08, 32'h00, 1, kindOther};
        tests[6] = '{32'h00, 32'h20, 4, kindReset};
        tests[7] = '{32'h00, 32'h20, 1, kindAdd};
        repeat (16) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;
        waitFetchStart(ok, n);
        timedOut = !ok;
        for (i = 0; i < numTests && !timedOut; i++) begin
            runTest(i, tests[i], ok);
            timedOut = !ok;
            testsRun++;
        end
        $display("%0d tests run, %0d control words checked, %0d errors",
            testsRun, watcher.checkCount, watcher.totalErrors());
        if (timedOut || watcher.totalErrors() != 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

`default_nettype wire
